// File: gb_cart_pkg.sv
// --------------------
// shared types and constants of the cartridge logic
// imported by the mapper, address map and cart RAM blocks
// --------------------
package gb_cart_pkg;

	// mapper families decoded from the header type byte
	typedef enum logic [2:0] {
		MBC_NONE,
		MBC_1,
		MBC_2,
		MBC_3,
		MBC_5
	} mbc_kind_t;

	typedef logic [15:0] cpu_addr_t;
	typedef logic [8:0]  rom_bank_t;      // 16k bank number, also the rom mask
	typedef logic [3:0]  ram_bank_t;      // 8k bank number, also the ram mask
	typedef logic [23:0] rom_word_addr_t; // 16 bit words of external memory

	// --------------------
	// cpu address windows, value of addr[15:13]
	// --------------------
	localparam logic [2:0] REGION_RAM_EN   = 3'b000; // 0000-1fff
	localparam logic [2:0] REGION_ROM_BANK = 3'b001; // 2000-3fff
	localparam logic [2:0] REGION_RAM_BANK = 3'b010; // 4000-5fff
	localparam logic [2:0] REGION_MODE     = 3'b011; // 6000-7fff
	localparam logic [2:0] REGION_CRAM     = 3'b101; // a000-bfff

	// low nibble written to 0000-1fff to open the ram
	localparam logic [3:0] RAM_ENABLE_KEY = 4'hA;

	// --------------------
	// header words seen on the download stream
	// --------------------
	localparam logic [24:0] HDR_TYPE_WORD = 25'h146; // type byte at 147 is the high byte
	localparam logic [24:0] HDR_SIZE_WORD = 25'h148; // rom size low, ram size high

endpackage

// File: gb_cart_if.sv
// --------------------
// bundles between the cartridge blocks: cpu bus, header info, bank state
// --------------------
`timescale 1ns/10ps

// cpu side cartridge bus
interface cart_bus_if;
	import gb_cart_pkg::*;

	cpu_addr_t   addr;
	logic        rd;
	logic        wr;  // one cycle strobe
	logic [7:0]  di;  // write byte

	modport src (output addr, rd, wr, di);
	modport mon (input addr, rd, wr, di);
endinterface

// fields taken from the cartridge header
interface cart_info_if;
	import gb_cart_pkg::*;

	mbc_kind_t kind;
	rom_bank_t rom_mask;
	ram_bank_t ram_mask;
	logic      ready;  // image loaded and header valid

	modport hdr  (output kind, rom_mask, ram_mask, ready);
	modport user (input kind, rom_mask, ram_mask, ready);
endinterface

// mapper register state
interface bank_if;
	import gb_cart_pkg::*;

	rom_bank_t rom_bank;
	ram_bank_t ram_bank;
	logic      mbc1_mode;
	logic      ram_enable;

	modport regs (output rom_bank, ram_bank, mbc1_mode, ram_enable);
	modport map  (input rom_bank, ram_bank, mbc1_mode, ram_enable);
endinterface

// File: cart_header_capture.sv
// --------------------
// snoops the image download and keeps the mapper type and size masks
// ready goes high once the download has finished
// --------------------
`timescale 1ns/10ps

module cart_header_capture (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        dl_active,
	input  logic        dl_wr,
	input  logic [24:0] dl_addr,
	input  logic [15:0] dl_data,
	cart_info_if.hdr    info
);
	import gb_cart_pkg::*;

	logic [7:0] type_code;
	logic [7:0] rom_code;
	logic [7:0] ram_code;
	logic       dl_active_d;
	logic       ready;
	mbc_kind_t  kind;
	rom_bank_t  rom_mask;
	ram_bank_t  ram_mask;

	// header bytes, held until the next download overwrites them
	always_ff @(posedge clk_sys) begin
		if (dl_wr && dl_addr == HDR_TYPE_WORD)
			type_code <= dl_data[15:8];
		if (dl_wr && dl_addr == HDR_SIZE_WORD) begin
			rom_code <= dl_data[7:0];   // offset 148
			ram_code <= dl_data[15:8];  // offset 149
		end
	end

	// ready drops while a download runs and returns after its end
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_active_d <= 1'b0;
			ready       <= 1'b0;
		end else begin
			dl_active_d <= dl_active;
			if (dl_active)
				ready <= 1'b0;
			else if (dl_active_d)
				ready <= 1'b1;
		end
	end

	// --------------------
	// decode
	// --------------------
	always_comb begin
		case (type_code) inside
			8'h01, 8'h02, 8'h03: kind = MBC_1;
			8'h05, 8'h06:        kind = MBC_2;
			[8'h0F:8'h13]:       kind = MBC_3;
			[8'h19:8'h1E]:       kind = MBC_5;
			default:             kind = MBC_NONE;
		endcase

		if (rom_code <= 8'd8)
			rom_mask = 9'h1FF >> (4'd8 - rom_code[3:0]);  // 2 << n banks
		else
			rom_mask = 9'h07F;  // odd sizes 52-54 fall back to 128 banks

		if (ram_code == 8'd3)
			ram_mask = 4'h3;    // 32k, 4 banks
		else if (ram_code < 8'd3)
			ram_mask = 4'h0;    // single bank or none
		else
			ram_mask = 4'hF;    // 128k
	end

	assign info.kind     = kind;
	assign info.rom_mask = rom_mask;
	assign info.ram_mask = ram_mask;
	assign info.ready    = ready;

endmodule

// File: mbc_bank_regs.sv
// --------------------
// mapper registers written by the cpu in 0000-7fff
// --------------------
`timescale 1ns/10ps

module mbc_bank_regs (
	input  logic       clk_sys,
	input  logic       reset,
	cart_bus_if.mon    bus,
	cart_info_if.user  info,
	bank_if.regs       bank
);
	import gb_cart_pkg::*;

	rom_bank_t  rom_bank;
	ram_bank_t  ram_bank;
	logic       mbc1_mode;
	logic       ram_enable;
	logic [2:0] region;
	logic       is_mbc5;
	logic       zero_bank;

	assign region  = bus.addr[15:13];
	assign is_mbc5 = (info.kind == MBC_5);

	// bank 0 is remapped to 1, each mapper looks at its own bit range
	always_comb begin
		case (info.kind)
			MBC_1:   zero_bank = (bus.di[4:0] == 5'd0);
			MBC_2:   zero_bank = (bus.di[3:0] == 4'd0);
			default: zero_bank = (bus.di[6:0] == 7'd0);
		endcase
	end

	// --------------------
	// register writes
	// --------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_bank   <= rom_bank_t'(1);
			ram_bank   <= '0;
			mbc1_mode  <= 1'b0;
			ram_enable <= 1'b0;
		end else if (bus.wr) begin
			case (region)
				REGION_RAM_EN: begin
					ram_enable <= (bus.di[3:0] == RAM_ENABLE_KEY);
				end
				REGION_ROM_BANK: begin
					if (is_mbc5) begin
						if (bus.addr[12])
							rom_bank[8] <= bus.di[0];     // 3000-3fff
						else
							rom_bank[7:0] <= bus.di;      // 2000-2fff, bank 0 allowed
					end else if (zero_bank) begin
						rom_bank <= rom_bank_t'(1);
					end else begin
						rom_bank <= {2'b00, bus.di[6:0]};
					end
				end
				REGION_RAM_BANK: begin
					if (is_mbc5)
						ram_bank <= bus.di[3:0];
					else
						ram_bank <= {2'b00, bus.di[1:0]};  // mbc1 bank2 or mbc3 ram bank
				end
				REGION_MODE: begin
					if (info.kind == MBC_1)
						mbc1_mode <= bus.di[0];
				end
				default: ;
			endcase
		end
	end

	assign bank.rom_bank   = rom_bank;
	assign bank.ram_bank   = ram_bank;
	assign bank.mbc1_mode  = mbc1_mode;
	assign bank.ram_enable = ram_enable;

endmodule

// File: mbc_addr_map.sv
// --------------------
// maps the cpu address onto the rom word address and the cart ram address
// --------------------
`timescale 1ns/10ps

module mbc_addr_map #(
	parameter int CRAM_BANK_BITS = 4
) (
	cart_bus_if.mon                       bus,
	cart_info_if.user                     info,
	bank_if.map                           bank,
	output gb_cart_pkg::rom_word_addr_t   rom_addr,
	output logic                          rom_oe,
	output logic [12+CRAM_BANK_BITS:0]    cram_addr
);
	import gb_cart_pkg::*;

	logic      in_cram;
	logic      low_win;
	logic [1:0] bank2;
	rom_bank_t sel_bank;
	rom_bank_t raw_bank;
	rom_bank_t eff_bank;
	ram_bank_t cram_bank;

	assign in_cram = (bus.addr[15:13] == REGION_CRAM);
	assign low_win = (bus.addr[15:14] == 2'b00);

	// mbc1 bank2 reaches 0000-3fff and the ram only in mode 1
	assign bank2    = bank.ram_bank[1:0] & {2{bus.addr[14] | bank.mbc1_mode}};
	assign sel_bank = low_win ? '0 : bank.rom_bank;

	always_comb begin
		case (info.kind)
			MBC_1:        raw_bank = {2'b00, bank2, sel_bank[4:0]};
			MBC_2, MBC_3: raw_bank = {2'b00, sel_bank[6:0]};
			MBC_5:        raw_bank = sel_bank;
			default:      raw_bank = {8'd0, bus.addr[14]};  // plain 32k
		endcase

		case (info.kind)
			MBC_1:        cram_bank = {2'b00, bank2} & info.ram_mask;
			MBC_3, MBC_5: cram_bank = bank.ram_bank & info.ram_mask;
			default:      cram_bank = '0;
		endcase
	end

	assign eff_bank = raw_bank & info.rom_mask;  // mirrors small roms

	// byte address is bank * 4000 + addr[13:0], halved for the word bus
	assign rom_addr  = {2'b00, eff_bank, bus.addr[13:1]};
	assign rom_oe    = bus.rd & ~in_cram & info.ready;
	assign cram_addr = {cram_bank[CRAM_BANK_BITS-1:0], bus.addr[12:0]};

endmodule

// File: cart_ram.sv
// --------------------
// banked cartridge ram and the read mux back to the cpu
// --------------------
`timescale 1ns/10ps

module cart_ram #(
	parameter int CRAM_BANK_BITS = 4
) (
	input  logic                         clk_sys,
	cart_bus_if.mon                      bus,
	cart_info_if.user                    info,
	bank_if.map                          bank,
	input  logic [12+CRAM_BANK_BITS:0]   cram_addr,
	input  logic [15:0]                  rom_data,
	output logic [7:0]                   cart_do
);
	import gb_cart_pkg::*;

	logic [7:0] mem [2**(13+CRAM_BANK_BITS)];
	logic [7:0] cram_q;
	logic       in_cram;

	assign in_cram = (bus.addr[15:13] == REGION_CRAM);

	// read every cycle, old data on a same-cycle write
	always_ff @(posedge clk_sys) begin
		if (bus.wr && in_cram && bank.ram_enable)
			mem[cram_addr] <= bus.di;
		cram_q <= mem[cram_addr];
	end

	always_comb begin
		if (!info.ready) begin
			cart_do = 8'h00;
		end else if (in_cram) begin
			if (!bank.ram_enable)
				cart_do = 8'hFF;                    // closed ram floats high
			else if (info.kind == MBC_2)
				cart_do = {4'hF, cram_q[3:0]};      // 4 bit wide on mbc2
			else
				cart_do = cram_q;
		end else begin
			cart_do = bus.addr[0] ? rom_data[15:8] : rom_data[7:0];
		end
	end

endmodule

// File: gb_cart_top.sv
// --------------------
// cartridge top: header snoop, mapper registers, address map and cart ram
// --------------------
`timescale 1ns/10ps

module gb_cart_top #(
	parameter int CRAM_BANK_BITS = 4  // 2 gives 32k of cart ram
) (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  logic                         dl_active,
	input  logic                         dl_wr,
	input  logic [24:0]                  dl_addr,
	input  logic [15:0]                  dl_data,
	input  gb_cart_pkg::cpu_addr_t       cart_addr,
	input  logic                         cart_rd,
	input  logic                         cart_wr,
	input  logic [7:0]                   cart_di,
	input  logic [15:0]                  rom_data,
	output gb_cart_pkg::rom_word_addr_t  rom_addr,
	output logic                         rom_oe,
	output logic [7:0]                   cart_do
);

	cart_bus_if  bus ();
	cart_info_if info ();
	bank_if      bank ();

	logic [12+CRAM_BANK_BITS:0] cram_addr;

	// cpu pins onto the bus bundle
	assign bus.addr = cart_addr;
	assign bus.rd   = cart_rd;
	assign bus.wr   = cart_wr;
	assign bus.di   = cart_di;

	cart_header_capture u_cart_header_capture (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.dl_wr     (dl_wr),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.info      (info)
	);

	mbc_bank_regs u_mbc_bank_regs (
		.clk_sys (clk_sys),
		.reset   (reset),
		.bus     (bus),
		.info    (info),
		.bank    (bank)
	);

	mbc_addr_map #(.CRAM_BANK_BITS(CRAM_BANK_BITS)) u_mbc_addr_map (
		.bus       (bus),
		.info      (info),
		.bank      (bank),
		.rom_addr  (rom_addr),
		.rom_oe    (rom_oe),
		.cram_addr (cram_addr)
	);

	cart_ram #(.CRAM_BANK_BITS(CRAM_BANK_BITS)) u_cart_ram (
		.clk_sys   (clk_sys),
		.bus       (bus),
		.info      (info),
		.bank      (bank),
		.cram_addr (cram_addr),
		.rom_data  (rom_data),
		.cart_do   (cart_do)
	);

endmodule

// File: tb_gb_cart_assert.sv
// --------------------
// bus and read-path properties, bound into the cartridge top level
// --------------------
`timescale 1ns/10ps

module tb_gb_cart_assert (
	input logic        clk_sys,
	input logic        reset,
	input logic        cart_rd,
	input logic        cart_wr,
	input logic [15:0] cart_addr,
	input logic [7:0]  cart_do,
	input logic        rom_oe,
	input logic        ready,
	input logic        ram_enable
);
	import gb_cart_pkg::*;

	rd_wr_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(cart_rd && cart_wr))
		else $error("cart_rd and cart_wr high in the same cycle");

	// closed ram reads back FF while the address is held
	closed_ram_ff: assert property (@(posedge clk_sys) disable iff (reset)
		(cart_rd && ready && !ram_enable && cart_addr[15:13] == REGION_CRAM) |=>
		(cart_do == 8'hFF || !cart_rd || !ready || !$stable(cart_addr)))
		else $error("cart ram read with ram disabled did not return FF");

	rom_oe_needs_ready: assert property (@(posedge clk_sys) disable iff (reset)
		!ready |-> !rom_oe)
		else $error("rom_oe high before the cartridge is ready");

endmodule

bind gb_cart_top tb_gb_cart_assert u_tb_gb_cart_assert (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.cart_rd    (cart_rd),
	.cart_wr    (cart_wr),
	.cart_addr  (cart_addr),
	.cart_do    (cart_do),
	.rom_oe     (rom_oe),
	.ready      (u_cart_header_capture.ready),
	.ram_enable (u_mbc_bank_regs.ram_enable)
);

// File: tb_gb_cart.sv
// --------------------
// random-stimulus testbench for the cartridge top level
// keeps its own mapper, rom and cart ram model and compares every read
// --------------------
`timescale 1ns/10ps

module tb_gb_cart;

	localparam int CRAM_BANK_BITS = 4;
	localparam int CRAM_SIZE      = 2**(13+CRAM_BANK_BITS);
	localparam int TIMEOUT_CYCLES = 20000;  // about 3200 two-cycle accesses fit 3 times over

	// mapper kinds of the model
	localparam int K_NONE = 0;
	localparam int K_MBC1 = 1;
	localparam int K_MBC2 = 2;
	localparam int K_MBC3 = 3;
	localparam int K_MBC5 = 5;

	logic        clk_sys;
	logic        reset;
	logic        dl_active;
	logic        dl_wr;
	logic [24:0] dl_addr;
	logic [15:0] dl_data;
	logic [15:0] cart_addr;
	logic        cart_rd;
	logic        cart_wr;
	logic [7:0]  cart_di;
	logic [15:0] rom_data;
	logic [23:0] rom_addr;
	logic        rom_oe;
	logic [7:0]  cart_do;

	// model state
	int         m_kind;
	logic [8:0] m_rom_mask;
	logic [3:0] m_ram_mask;
	logic       m_ready;
	logic [8:0] m_rom_bank;
	logic [3:0] m_ram_bank;
	logic       m_mode;
	logic       m_ram_en;
	logic [7:0] m_cram [CRAM_SIZE];
	bit         m_valid [CRAM_SIZE];  // set once a byte has been written

	int cycles = 0;
	int checks = 0;
	int errors = 0;

	gb_cart_top #(.CRAM_BANK_BITS(CRAM_BANK_BITS)) u_gb_cart_top (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.dl_wr     (dl_wr),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.cart_addr (cart_addr),
		.cart_rd   (cart_rd),
		.cart_wr   (cart_wr),
		.cart_di   (cart_di),
		.rom_data  (rom_data),
		.rom_addr  (rom_addr),
		.rom_oe    (rom_oe),
		.cart_do   (cart_do)
	);

	// --------------------
	// rom contents and model rules
	// --------------------
	function automatic logic [15:0] rom_word(input logic [23:0] a);
		logic [31:0] h;
		h = {8'h00, a} * 32'h9E37_79B1;
		h = h ^ (h >> 15);
		h = h * 32'h85EB_CA6B;
		return h[31:16] ^ h[15:0];
	endfunction

	assign rom_data = rom_word(rom_addr);  // rom answers without delay

	function automatic int decode_kind(input logic [7:0] t);
		if (t >= 8'h01 && t <= 8'h03)
			return K_MBC1;
		if (t == 8'h05 || t == 8'h06)
			return K_MBC2;
		if (t >= 8'h0F && t <= 8'h13)
			return K_MBC3;
		if (t >= 8'h19 && t <= 8'h1E)
			return K_MBC5;
		return K_NONE;
	endfunction

	function automatic logic [8:0] rom_mask_of(input logic [7:0] code);
		if (code > 8'd8)
			return 9'h07F;
		return 9'((32'd2 << code) - 32'd1);
	endfunction

	function automatic logic [3:0] ram_mask_of(input logic [7:0] code);
		if (code == 8'd3)
			return 4'h3;
		if (code < 8'd3)
			return 4'h0;
		return 4'hF;
	endfunction

	function automatic logic [12+CRAM_BANK_BITS:0] cram_index(input logic [15:0] a);
		logic [3:0] b;
		case (m_kind)
			K_MBC1:         b = m_mode ? {2'b00, m_ram_bank[1:0]} : 4'h0;
			K_MBC3, K_MBC5: b = m_ram_bank;
			default:        b = 4'h0;
		endcase
		b = b & m_ram_mask;
		return {b[CRAM_BANK_BITS-1:0], a[12:0]};
	endfunction

	function automatic logic [23:0] mapped_rom_addr(input logic [15:0] a);
		logic [8:0]  b;
		logic [1:0]  bank2;
		logic [23:0] byte_addr;
		bank2 = (a[14] || m_mode) ? m_ram_bank[1:0] : 2'b00;
		case (m_kind)
			K_MBC1:         b = {2'b00, bank2, a[14] ? m_rom_bank[4:0] : 5'd0};
			K_MBC2, K_MBC3: b = a[14] ? {2'b00, m_rom_bank[6:0]} : 9'd0;
			K_MBC5:         b = a[14] ? m_rom_bank : 9'd0;
			default:        b = {8'd0, a[14]};  // linear 32k image
		endcase
		b = b & m_rom_mask;
		byte_addr = {1'b0, b, a[13:0]};
		return byte_addr >> 1;
	endfunction

	function automatic logic [7:0] rom_byte(input logic [15:0] a);
		logic [15:0] w;
		w = rom_word(mapped_rom_addr(a));
		return a[0] ? w[15:8] : w[7:0];
	endfunction

	task automatic model_write(input logic [15:0] a, input logic [7:0] d);
		logic [12+CRAM_BANK_BITS:0] idx;
		idx = cram_index(a);
		if (a[15:13] == 3'b101) begin
			if (m_ram_en) begin
				m_cram[idx]  = d;
				m_valid[idx] = 1'b1;
			end
		end else if (!a[15]) begin
			case (a[14:13])
				2'd0: m_ram_en = (d[3:0] == 4'hA);
				2'd1: begin
					if (m_kind == K_MBC5) begin
						if (a[12])
							m_rom_bank[8] = d[0];
						else
							m_rom_bank[7:0] = d;
					end else if ((m_kind == K_MBC1 && d[4:0] == 5'd0) ||
							(m_kind == K_MBC2 && d[3:0] == 4'd0) ||
							(m_kind != K_MBC1 && m_kind != K_MBC2 && d[6:0] == 7'd0)) begin
						m_rom_bank = 9'd1;
					end else begin
						m_rom_bank = {2'b00, d[6:0]};
					end
				end
				2'd2: m_ram_bank = (m_kind == K_MBC5) ? d[3:0] : {2'b00, d[1:0]};
				default: begin
					if (m_kind == K_MBC1)
						m_mode = d[0];
				end
			endcase
		end
	endtask

	// --------------------
	// stimulus
	// --------------------
	task automatic step();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		repeat (3) step();
		reset      = 1'b0;
		m_ready    = 1'b0;
		m_rom_bank = 9'd1;
		m_ram_bank = 4'h0;
		m_mode     = 1'b0;
		m_ram_en   = 1'b0;
	endtask

	// writes the header words amid random filler and then drops dl_active
	task automatic download(input logic [7:0] type_code, input logic [7:0] rom_code,
			input logic [7:0] ram_code);
		step();
		dl_active = 1'b1;
		m_ready   = 1'b0;
		for (int w = 'h140; w <= 'h14E; w += 2) begin
			step();
			dl_wr   = 1'b1;
			dl_addr = 25'(w);
			if (w == 'h146)
				dl_data = {type_code, 8'($urandom)};
			else if (w == 'h148)
				dl_data = {ram_code, rom_code};
			else
				dl_data = 16'($urandom);
		end
		step();
		dl_wr = 1'b0;
		step();
		dl_active  = 1'b0;
		m_kind     = decode_kind(type_code);
		m_rom_mask = rom_mask_of(rom_code);
		m_ram_mask = ram_mask_of(ram_code);
		m_ready    = 1'b1;
	endtask

	task automatic cart_write(input logic [15:0] a, input logic [7:0] d);
		step();
		cart_rd   = 1'b0;
		cart_addr = a;
		cart_di   = d;
		cart_wr   = 1'b1;
		@(negedge clk_sys);
		checks++;
		if (rom_oe !== 1'b0) begin
			errors++;
			$display("CHECK FAILED rom_oe addr %h: got %h, expected %h", a, rom_oe, 1'b0);
		end
		step();
		cart_wr = 1'b0;
		model_write(a, d);
	endtask

	// address held two cycles and compared in the second one
	task automatic check_read(input logic [15:0] a);
		logic [7:0]                 exp;
		logic [23:0]                exp_addr;
		logic                       known;
		logic                       in_ram;
		logic [12+CRAM_BANK_BITS:0] idx;
		step();
		cart_addr = a;
		cart_rd   = 1'b1;
		@(posedge clk_sys);
		@(negedge clk_sys);
		exp      = 8'h00;
		known    = 1'b1;
		in_ram   = (a[15:13] == 3'b101);
		idx      = cram_index(a);
		exp_addr = mapped_rom_addr(a);
		if (!m_ready)
			exp = 8'h00;
		else if (in_ram) begin
			if (!m_ram_en)
				exp = 8'hFF;
			else if (!m_valid[idx])
				known = 1'b0;  // content undefined until first written
			else if (m_kind == K_MBC2)
				exp = {4'hF, m_cram[idx][3:0]};
			else
				exp = m_cram[idx];
		end else
			exp = rom_byte(a);
		checks++;
		if (known && cart_do !== exp) begin
			errors++;
			$display("CHECK FAILED cart_do addr %h: got %h, expected %h", a, cart_do, exp);
		end
		if (rom_oe !== (m_ready && !in_ram)) begin
			errors++;
			$display("CHECK FAILED rom_oe addr %h: got %h, expected %h", a, rom_oe,
				m_ready && !in_ram);
		end
		if (m_ready && !in_ram && rom_addr !== exp_addr) begin
			errors++;
			$display("CHECK FAILED rom_addr addr %h: got %h, expected %h", a, rom_addr,
				exp_addr);
		end
	endtask

	function automatic logic [15:0] ram_addr();
		return {3'b101, 3'($urandom), 8'h00, 2'($urandom)};  // few offsets so reads hit
	endfunction

	task automatic random_ops(input int n, input bit use_ram);
		int          op;
		logic [15:0] a;
		logic [7:0]  d;
		repeat (n) begin
			op = $urandom_range(0, use_ram ? 9 : 5);
			d  = 8'($urandom);
			if (op < 2) begin
				a = {1'b0, 2'($urandom), 13'($urandom)};
				if (a[14:13] == 2'b00 && $urandom_range(0, 1) == 1)
					d[3:0] = 4'hA;
				else if ($urandom_range(0, 3) == 0)
					d = 8'h00;  // bank zero more often
				cart_write(a, d);
			end else if (op < 6)
				check_read({1'b0, 15'($urandom)});
			else if (op < 8)
				cart_write(ram_addr(), d);
			else
				check_read(ram_addr());
		end
	endtask

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: accesses still running after %0d cycles", cycles);
			$display("TESTS FAILED");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'ha4e9));
		reset     = 1'b1;
		dl_active = 1'b0;
		dl_wr     = 1'b0;
		dl_addr   = '0;
		dl_data   = '0;
		cart_addr = '0;
		cart_rd   = 1'b0;
		cart_wr   = 1'b0;
		cart_di   = '0;
		m_kind    = K_NONE;
		apply_reset();

		random_ops(60, 1'b1);                // all reads give 0 before the first download
		download(8'h00, 8'h00, 8'h00);       // no mapper with a 32k image
		random_ops(300, 1'b0);

		apply_reset();
		download(8'h03, 8'h04, 8'h03);       // mbc1 with 32 banks
		random_ops(450, 1'b1);
		download(8'h01, 8'h06, 8'h03);       // mbc1 with 128 banks so bank2 counts
		random_ops(450, 1'b1);

		apply_reset();
		download(8'h19, 8'h06, 8'h00);       // mbc5 where bit 8 mirrors away
		random_ops(450, 1'b0);
		download(8'h1B, 8'h08, 8'h04);       // mbc5 with 512 banks and 128k ram
		random_ops(550, 1'b1);

		apply_reset();
		download(8'h13, 8'h05, 8'h03);       // mbc3 with 4 ram banks
		random_ops(550, 1'b1);

		apply_reset();
		download(8'h06, 8'h03, 8'h00);       // mbc2
		random_ops(400, 1'b1);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: all.f
gb_cart_pkg.sv
gb_cart_if.sv
cart_header_capture.sv
mbc_bank_regs.sv
mbc_addr_map.sv
cart_ram.sv
gb_cart_top.sv
tb_gb_cart_assert.sv
tb_gb_cart.sv

// File: Makefile
# Verilator build and run of the cartridge testbench

VERILATOR ?= verilator
TOP       ?= tb_gb_cart
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
